/* source/opf_macros.svh */
// widths, opcodes and SPR numbers for the operand fetch stage, included by package and RTL
`ifndef OPF_MACROS_SVH
`define OPF_MACROS_SVH

// datapath and field widths
`define OPF_DWIDTH     32
`define OPF_NREG       32
`define OPF_IMM_WIDTH  16
`define OPF_OPCD_WIDTH 6
`define OPF_XO_WIDTH   10
`define OPF_SPR_WIDTH  10

// primary opcodes
`define OPF_OP_MULLI   6'd7
`define OPF_OP_SUBFIC  6'd8
`define OPF_OP_CMPLI   6'd10
`define OPF_OP_CMPI    6'd11
`define OPF_OP_ADDIC   6'd12
`define OPF_OP_ADDI    6'd14
`define OPF_OP_ADDIS   6'd15
`define OPF_OP_ORI     6'd24
`define OPF_OP_ORIS    6'd25
`define OPF_OP_ANDI    6'd28
`define OPF_OP_ANDIS   6'd29
`define OPF_OP_ALU_XO  6'd31
`define OPF_OP_LWZ     6'd32
`define OPF_OP_STW     6'd36

// extended opcodes, top bit is OE for the XO-form arithmetic
`define OPF_XO_CMP     10'd0
`define OPF_XO_LWZX    10'd23
`define OPF_XO_CMPL    10'd32
`define OPF_XO_SUBF    10'd40
`define OPF_XO_NEG     10'd104
`define OPF_XO_ADDE    10'd138
`define OPF_XO_ADDZE   10'd202
`define OPF_XO_ADDME   10'd234
`define OPF_XO_MFSPR   10'd339
`define OPF_XO_SRAW    10'd792
`define OPF_XO_SRAWI   10'd824

// SPR numbers, halves already swapped back
`define OPF_SPR_XER    10'd1
`define OPF_SPR_LNK    10'd8
`define OPF_SPR_CTR    10'd9

// XER bits
`define OPF_XER_SO     31
`define OPF_XER_CA     29

`endif

/* source/opf_pkg.sv */
// shared word and instruction field types plus field accessors, referenced by scoped name
`include "opf_macros.svh"

package opf_pkg;

  typedef logic [`OPF_DWIDTH-1:0]        word_t;
  typedef logic [31:0]                   inst_t;
  typedef logic [$clog2(`OPF_NREG)-1:0]  reg_index_t;
  typedef logic [`OPF_SPR_WIDTH-1:0]     spr_num_t;
  typedef logic [`OPF_OPCD_WIDTH-1:0]    opcode_t;
  typedef logic [`OPF_XO_WIDTH-1:0]      xo_t;
  typedef logic [`OPF_IMM_WIDTH-1:0]     imm_t;

  // ------------------------------------------------------------
  // field extraction, PowerPC numbering counts from the msb
  // ------------------------------------------------------------
  function automatic opcode_t get_opcode(inst_t inst);
    return inst[31:26];
  endfunction

  function automatic reg_index_t get_rt(inst_t inst);
    return inst[25:21];
  endfunction

  function automatic reg_index_t get_ra(inst_t inst);
    return inst[20:16];
  endfunction

  function automatic reg_index_t get_rb(inst_t inst);
    return inst[15:11];
  endfunction

  function automatic imm_t get_imm(inst_t inst);
    return inst[15:0];
  endfunction

  function automatic xo_t get_xo(inst_t inst);
    return inst[10:1];
  endfunction

  // spr field is stored with its two halves swapped
  function automatic spr_num_t get_spr(inst_t inst);
    return {inst[15:11], inst[20:16]};
  endfunction

endpackage

/* source/regfile_if.sv */
// read port bundle between the register file and the operand fetch logic
`timescale 1ns/10ps

interface regfile_if;

  // read selects, driven by the fetch stage
  opf_pkg::reg_index_t sel_a;
  opf_pkg::reg_index_t sel_b;
  opf_pkg::reg_index_t sel_c;

  // gpr read data
  opf_pkg::word_t gpr_a;
  opf_pkg::word_t gpr_b;
  opf_pkg::word_t gpr_c;

  // spr contents, always visible
  opf_pkg::word_t xer;
  opf_pkg::word_t ctr;
  opf_pkg::word_t lnk;

  // fetch side picks registers and takes the data
  modport fetch (
    output sel_a, sel_b, sel_c,
    input  gpr_a, gpr_b, gpr_c, xer, ctr, lnk
  );

  // file side answers combinationally
  modport file (
    input  sel_a, sel_b, sel_c,
    output gpr_a, gpr_b, gpr_c, xer, ctr, lnk
  );

endinterface

/* source/register_file.sv */
// 32 GPRs plus XER, CTR and LNK with one write port each and combinational reads
`timescale 1ns/10ps
`include "opf_macros.svh"

module register_file (
  input  logic                clk,
  input  logic                reset,
  regfile_if.file             rf,
  input  logic                gpr_we,
  input  opf_pkg::reg_index_t gpr_waddr,
  input  opf_pkg::word_t      gpr_wdata,
  input  logic                spr_we,
  input  opf_pkg::spr_num_t   spr_wnum,
  input  opf_pkg::word_t      spr_wdata
);

  opf_pkg::word_t gpr [`OPF_NREG];
  opf_pkg::word_t xer;
  opf_pkg::word_t ctr;
  opf_pkg::word_t lnk;

  // ------------------------------------------------------------
  // gpr write port
  // ------------------------------------------------------------
  // r0 is a normal register here, RA|0 lives in the fetch stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `OPF_NREG; i++) begin
        gpr[i] <= '0;
      end
    end else if (gpr_we) begin
      gpr[gpr_waddr] <= gpr_wdata;
    end
  end

  // ------------------------------------------------------------
  // spr write port
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      xer <= '0;
      ctr <= '0;
      lnk <= '0;
    end else if (spr_we) begin
      case (spr_wnum)
        `OPF_SPR_XER: xer <= spr_wdata;
        `OPF_SPR_CTR: ctr <= spr_wdata;
        `OPF_SPR_LNK: lnk <= spr_wdata;
        // unknown numbers dropped silently
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // reads
  // ------------------------------------------------------------
  // same-edge writes land before the instruction that reads them
  assign rf.gpr_a = gpr[rf.sel_a];
  assign rf.gpr_b = gpr[rf.sel_b];
  assign rf.gpr_c = gpr[rf.sel_c];

  // sprs go out whole, fetch picks bits or words
  assign rf.xer = xer;
  assign rf.ctr = ctr;
  assign rf.lnk = lnk;

endmodule

/* source/immediate_extract.sv */
// turns the D field into a 32-bit immediate and says whether operand B takes it
`timescale 1ns/10ps
`include "opf_macros.svh"

module immediate_extract (
  input  opf_pkg::inst_t inst,
  output opf_pkg::word_t imm,
  output logic           use_imm
);

  localparam int FILL = `OPF_DWIDTH - `OPF_IMM_WIDTH;

  opf_pkg::opcode_t opcode;
  opf_pkg::imm_t    d;

  assign opcode = opf_pkg::get_opcode(inst);
  assign d      = opf_pkg::get_imm(inst);

  // ------------------------------------------------------------
  // immediate forms
  // ------------------------------------------------------------
  always_comb begin
    case (opcode)
      // arithmetic, compare and addressing, sign extended
      `OPF_OP_ADDI, `OPF_OP_ADDIC, `OPF_OP_SUBFIC, `OPF_OP_CMPI,
      `OPF_OP_LWZ, `OPF_OP_STW, `OPF_OP_MULLI:
        imm = {{FILL{d[`OPF_IMM_WIDTH-1]}}, d};

      // shifted into the upper half
      `OPF_OP_ADDIS, `OPF_OP_ORIS, `OPF_OP_ANDIS:
        imm = {d, {FILL{1'b0}}};

      // logical and unsigned compare, zero extended
      default:
        imm = {{FILL{1'b0}}, d};
    endcase
  end

  // ------------------------------------------------------------
  // B operand source
  // ------------------------------------------------------------
  // every D-form op listed, the XO group reads registers
  always_comb begin
    case (opcode)
      `OPF_OP_ADDI, `OPF_OP_ADDIS, `OPF_OP_ADDIC, `OPF_OP_SUBFIC,
      `OPF_OP_CMPI, `OPF_OP_CMPLI, `OPF_OP_ORI, `OPF_OP_ORIS,
      `OPF_OP_ANDI, `OPF_OP_ANDIS, `OPF_OP_LWZ, `OPF_OP_STW,
      `OPF_OP_MULLI:
        use_imm = 1'b1;
      default:
        use_imm = 1'b0;
    endcase
  end

endmodule

/* source/operand_fetch.sv */
// operand fetch stage: registers the instruction, selects A, B, C and carry, registers the bundle
`timescale 1ns/10ps
`include "opf_macros.svh"

module operand_fetch (
  input  logic           clk,
  input  logic           reset,
  input  logic           inst_valid,
  input  opf_pkg::inst_t inst,
  regfile_if.fetch       rf,
  output logic           ops_valid,
  output logic           op_cin,
  output logic           op_so,
  output opf_pkg::word_t op_a,
  output opf_pkg::word_t op_b,
  output opf_pkg::word_t op_c
);

  // instruction register
  opf_pkg::inst_t   ir;
  logic             ir_valid;

  // decoded fields and flags
  opf_pkg::opcode_t opcode;
  opf_pkg::xo_t     xo;
  logic             is_xo_group;
  logic             xo_subf, xo_neg, xo_adde, xo_addze, xo_addme;
  logic             xo_cmp, xo_cmpl, xo_sraw, xo_mfspr, xo_lwzx;
  logic             ra_zero_form;

  // next bundle
  opf_pkg::word_t   imm;
  logic             use_imm;
  opf_pkg::word_t   spr_in;
  opf_pkg::word_t   next_a, next_b, next_c;
  logic             next_cin;

  // OE bit ignored on XO-form arithmetic
  function automatic logic xo_arith(opf_pkg::xo_t val, opf_pkg::xo_t code);
    return val[`OPF_XO_WIDTH-2:0] == code[`OPF_XO_WIDTH-2:0];
  endfunction

  // ------------------------------------------------------------
  // instruction register
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ir_valid <= 1'b0;
    end else begin
      ir_valid <= inst_valid;
    end
  end

  // only valid words are captured
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      ir <= inst;
    end
  end

  // selects straight from the registered word
  assign rf.sel_a = opf_pkg::get_ra(ir);
  assign rf.sel_b = opf_pkg::get_rb(ir);
  assign rf.sel_c = opf_pkg::get_rt(ir);

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  assign opcode      = opf_pkg::get_opcode(ir);
  assign xo          = opf_pkg::get_xo(ir);
  assign is_xo_group = opcode == `OPF_OP_ALU_XO;

  assign xo_subf  = is_xo_group && xo_arith(xo, `OPF_XO_SUBF);
  assign xo_neg   = is_xo_group && xo_arith(xo, `OPF_XO_NEG);
  assign xo_adde  = is_xo_group && xo_arith(xo, `OPF_XO_ADDE);
  assign xo_addze = is_xo_group && xo_arith(xo, `OPF_XO_ADDZE);
  assign xo_addme = is_xo_group && xo_arith(xo, `OPF_XO_ADDME);
  // x-form, full match
  assign xo_cmp   = is_xo_group && xo == `OPF_XO_CMP;
  assign xo_cmpl  = is_xo_group && xo == `OPF_XO_CMPL;
  assign xo_sraw  = is_xo_group && (xo == `OPF_XO_SRAW || xo == `OPF_XO_SRAWI);
  assign xo_mfspr = is_xo_group && xo == `OPF_XO_MFSPR;
  assign xo_lwzx  = is_xo_group && xo == `OPF_XO_LWZX;

  // RA|0 users
  assign ra_zero_form = opcode == `OPF_OP_ADDI || opcode == `OPF_OP_ADDIS ||
                        opcode == `OPF_OP_LWZ || opcode == `OPF_OP_STW || xo_lwzx;

  immediate_extract u_imm (
    .inst    (ir),
    .imm     (imm),
    .use_imm (use_imm)
  );

  // ------------------------------------------------------------
  // operand multiplexers
  // ------------------------------------------------------------
  assign next_a = (ra_zero_form && rf.sel_a == '0) ? '0 : rf.gpr_a;

  // unused spr numbers read as zero
  always_comb begin
    case (opf_pkg::get_spr(ir))
      `OPF_SPR_XER: spr_in = rf.xer;
      `OPF_SPR_CTR: spr_in = rf.ctr;
      `OPF_SPR_LNK: spr_in = rf.lnk;
      default:      spr_in = '0;
    endcase
  end

  always_comb begin
    if (xo_mfspr) begin
      next_b = spr_in;
    end else if (xo_neg || xo_addze) begin
      next_b = '0;
    end else if (xo_addme) begin
      next_b = '1;
    end else if (use_imm) begin
      next_b = imm;
    end else begin
      next_b = rf.gpr_b;
    end
  end

  // shift right algebraic wants the sign of RA as fill
  assign next_c = xo_sraw ? {`OPF_DWIDTH{rf.gpr_a[`OPF_DWIDTH-1]}} : rf.gpr_c;

  // ------------------------------------------------------------
  // carry in
  // ------------------------------------------------------------
  always_comb begin
    case (opcode)
      `OPF_OP_CMPI, `OPF_OP_CMPLI, `OPF_OP_SUBFIC:
        next_cin = 1'b1;
      `OPF_OP_ALU_XO:
        if (xo_subf || xo_cmp || xo_cmpl || xo_neg) begin
          next_cin = 1'b1;
        end else if (xo_adde || xo_addme || xo_addze) begin
          next_cin = rf.xer[`OPF_XER_CA];
        end else begin
          next_cin = 1'b0;
        end
      default:
        next_cin = 1'b0;
    endcase
  end

  // ------------------------------------------------------------
  // output bundle
  // ------------------------------------------------------------
  // payload loads with a valid word, held otherwise
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ops_valid <= 1'b0;
      op_a      <= '0;
      op_b      <= '0;
      op_c      <= '0;
      op_cin    <= 1'b0;
      op_so     <= 1'b0;
    end else begin
      ops_valid <= ir_valid;
      if (ir_valid) begin
        op_a   <= next_a;
        op_b   <= next_b;
        op_c   <= next_c;
        op_cin <= next_cin;
        op_so  <= rf.xer[`OPF_XER_SO];
      end
    end
  end

endmodule

/* source/operand_fetch_top.sv */
// top level with plain ports, joins the register file and the operand fetch stage
`timescale 1ns/10ps

module operand_fetch_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                inst_valid,
  input  opf_pkg::inst_t      inst,
  input  logic                gpr_we,
  input  opf_pkg::reg_index_t gpr_waddr,
  input  opf_pkg::word_t      gpr_wdata,
  input  logic                spr_we,
  input  opf_pkg::spr_num_t   spr_wnum,
  input  opf_pkg::word_t      spr_wdata,
  output logic                ops_valid,
  output logic                op_cin,
  output logic                op_so,
  output opf_pkg::word_t      op_a,
  output opf_pkg::word_t      op_b,
  output opf_pkg::word_t      op_c
);

  // combinational read bus
  regfile_if rf_bus ();

  // storage, writes from outside
  register_file u_register_file (
    .clk       (clk),
    .reset     (reset),
    .rf        (rf_bus.file),
    .gpr_we    (gpr_we),
    .gpr_waddr (gpr_waddr),
    .gpr_wdata (gpr_wdata),
    .spr_we    (spr_we),
    .spr_wnum  (spr_wnum),
    .spr_wdata (spr_wdata)
  );

  // two register stages, inst to ops
  operand_fetch u_operand_fetch (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rf         (rf_bus.fetch),
    .ops_valid  (ops_valid),
    .op_cin     (op_cin),
    .op_so      (op_so),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_c       (op_c)
  );

endmodule

/* tests/operand_fetch_asserts.sv */
// concurrent timing checks on the operand fetch top level, attached to it by bind
`timescale 1ns/10ps

module operand_fetch_asserts (
  input logic           clk,
  input logic           reset,
  input logic           inst_valid,
  input logic           ops_valid,
  input logic           op_cin,
  input opf_pkg::word_t op_b
);

  // ------------------------------------------------------------
  // reset and latency
  // ------------------------------------------------------------
  // bundle stays clear while reset is high
  valid_low_in_reset: assert property (@(posedge clk) reset |-> !ops_valid)
    else $error("ops_valid high while reset is asserted");

  // one instruction in, one bundle out two edges later
  fixed_latency: assert property (@(posedge clk) disable iff (reset)
    ops_valid == $past(inst_valid, 2))
    else $error("ops_valid does not follow inst_valid by two cycles");

  // ------------------------------------------------------------
  // payload
  // ------------------------------------------------------------
  // carry and B are always driven from known sources
  known_payload: assert property (@(posedge clk) disable iff (reset)
    ops_valid |-> !$isunknown({op_cin, op_b}))
    else $error("op_cin or op_b has unknown bits while ops_valid is high");

endmodule

bind operand_fetch_top operand_fetch_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .inst_valid (inst_valid),
  .ops_valid  (ops_valid),
  .op_cin     (op_cin),
  .op_b       (op_b)
);

/* tests/tb_operand_fetch.sv */
// directed testbench for the operand fetch top level, run from the Makefile with Verilator
`timescale 1ns/10ps
`include "opf_macros.svh"

module tb_operand_fetch;

  localparam int timeout = 20;
  // plain add, only needed as an ordinary register-register op
  localparam opf_pkg::xo_t xo_add = 10'd266;

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  logic                inst_valid = 1'b0;
  opf_pkg::inst_t      inst = '0;
  logic                gpr_we = 1'b0;
  opf_pkg::reg_index_t gpr_waddr = '0;
  opf_pkg::word_t      gpr_wdata = '0;
  logic                spr_we = 1'b0;
  opf_pkg::spr_num_t   spr_wnum = '0;
  opf_pkg::word_t      spr_wdata = '0;
  logic                ops_valid;
  logic                op_cin;
  logic                op_so;
  opf_pkg::word_t      op_a;
  opf_pkg::word_t      op_b;
  opf_pkg::word_t      op_c;

  // shadow of the register file for the reference model
  opf_pkg::word_t shadow_gpr [32] = '{default: '0};
  opf_pkg::word_t shadow_xer = '0;
  opf_pkg::word_t shadow_ctr = '0;
  opf_pkg::word_t shadow_lnk = '0;
  opf_pkg::inst_t prog [$];
  integer         seed;

  // random pick lists for the burst
  opf_pkg::opcode_t d_ops [13] = '{`OPF_OP_ADDI, `OPF_OP_ADDIS, `OPF_OP_ADDIC, `OPF_OP_SUBFIC,
    `OPF_OP_CMPI, `OPF_OP_CMPLI, `OPF_OP_ORI, `OPF_OP_ORIS, `OPF_OP_ANDI, `OPF_OP_ANDIS,
    `OPF_OP_LWZ, `OPF_OP_STW, `OPF_OP_MULLI};
  opf_pkg::xo_t x_ops [12] = '{`OPF_XO_SUBF, `OPF_XO_NEG, `OPF_XO_ADDE, `OPF_XO_ADDZE,
    `OPF_XO_ADDME, `OPF_XO_CMP, `OPF_XO_CMPL, `OPF_XO_SRAW, `OPF_XO_SRAWI, `OPF_XO_MFSPR,
    `OPF_XO_LWZX, xo_add};

  operand_fetch_top UUT (.*);

  always #2 clk = ~clk;

  // ------------------------------------------------------------
  // reporting and checks
  // ------------------------------------------------------------
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input opf_pkg::word_t exp,
                            input opf_pkg::word_t got);
    assert (got === exp) else fail_run($sformatf("Fail %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    assert (got === exp) else fail_run($sformatf("Fail %s expected %h got %h", name, exp, got));
  endtask

  // ------------------------------------------------------------
  // register loading, one write per falling edge
  // ------------------------------------------------------------
  task automatic load_gpr(input opf_pkg::reg_index_t idx, input opf_pkg::word_t val);
    gpr_we = 1'b1;
    gpr_waddr = idx;
    gpr_wdata = val;
    @(negedge clk);
    gpr_we = 1'b0;
    shadow_gpr[idx] = val;
  endtask

  task automatic load_spr(input opf_pkg::spr_num_t num, input opf_pkg::word_t val);
    spr_we = 1'b1;
    spr_wnum = num;
    spr_wdata = val;
    @(negedge clk);
    spr_we = 1'b0;
    // unknown numbers leave the file untouched
    case (num)
      `OPF_SPR_XER: shadow_xer = val;
      `OPF_SPR_CTR: shadow_ctr = val;
      `OPF_SPR_LNK: shadow_lnk = val;
      default: ;
    endcase
  endtask

  // ------------------------------------------------------------
  // instruction encoders
  // ------------------------------------------------------------
  function automatic opf_pkg::inst_t d_form(input opf_pkg::opcode_t op,
      input opf_pkg::reg_index_t rt, input opf_pkg::reg_index_t ra, input opf_pkg::imm_t d);
    return {op, rt, ra, d};
  endfunction

  function automatic opf_pkg::inst_t x_form(input opf_pkg::reg_index_t rt,
      input opf_pkg::reg_index_t ra, input opf_pkg::reg_index_t rb, input opf_pkg::xo_t xo);
    return {`OPF_OP_ALU_XO, rt, ra, rb, xo, 1'b0};
  endfunction

  // spr halves swapped in the encoding
  function automatic opf_pkg::inst_t mfspr_form(input opf_pkg::reg_index_t rt,
      input opf_pkg::spr_num_t spr);
    return {`OPF_OP_ALU_XO, rt, spr[4:0], spr[9:5], `OPF_XO_MFSPR, 1'b0};
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  function automatic void model(input opf_pkg::inst_t i, output opf_pkg::word_t a,
      output opf_pkg::word_t b, output opf_pkg::word_t c, output logic cin);
    opf_pkg::opcode_t op;
    opf_pkg::xo_t     xo;
    opf_pkg::word_t   imm;
    opf_pkg::word_t   spr_val;
    logic             xg;
    op = i[31:26];
    xo = i[10:1];
    xg = op == `OPF_OP_ALU_XO;
    // RA|0 forms
    if (i[20:16] == 5'd0 && (op inside {`OPF_OP_ADDI, `OPF_OP_ADDIS, `OPF_OP_LWZ, `OPF_OP_STW}
        || (xg && xo == `OPF_XO_LWZX)))
      a = '0;
    else
      a = shadow_gpr[i[20:16]];
    case (op)
      `OPF_OP_ADDI, `OPF_OP_ADDIC, `OPF_OP_SUBFIC, `OPF_OP_CMPI, `OPF_OP_LWZ, `OPF_OP_STW,
      `OPF_OP_MULLI: imm = {{16{i[15]}}, i[15:0]};
      `OPF_OP_ADDIS, `OPF_OP_ORIS, `OPF_OP_ANDIS: imm = {i[15:0], 16'h0000};
      default: imm = {16'h0000, i[15:0]};
    endcase
    case ({i[15:11], i[20:16]})
      `OPF_SPR_XER: spr_val = shadow_xer;
      `OPF_SPR_CTR: spr_val = shadow_ctr;
      `OPF_SPR_LNK: spr_val = shadow_lnk;
      default: spr_val = '0;
    endcase
    // OE bit does not take part in the arithmetic matches
    if (xg && xo == `OPF_XO_MFSPR)
      b = spr_val;
    else if (xg && (xo[8:0] == 9'(`OPF_XO_NEG) || xo[8:0] == 9'(`OPF_XO_ADDZE)))
      b = '0;
    else if (xg && xo[8:0] == 9'(`OPF_XO_ADDME))
      b = '1;
    else if (!xg && op inside {d_ops})
      b = imm;
    else
      b = shadow_gpr[i[15:11]];
    if (xg && (xo == `OPF_XO_SRAW || xo == `OPF_XO_SRAWI))
      c = {32{shadow_gpr[i[20:16]][31]}};
    else
      c = shadow_gpr[i[25:21]];
    if (op inside {`OPF_OP_CMPI, `OPF_OP_CMPLI, `OPF_OP_SUBFIC})
      cin = 1'b1;
    else if (xg && (xo[8:0] == 9'(`OPF_XO_SUBF) || xo[8:0] == 9'(`OPF_XO_NEG) ||
             xo == `OPF_XO_CMP || xo == `OPF_XO_CMPL))
      cin = 1'b1;
    else if (xg && (xo[8:0] == 9'(`OPF_XO_ADDE) || xo[8:0] == 9'(`OPF_XO_ADDME) ||
             xo[8:0] == 9'(`OPF_XO_ADDZE)))
      cin = shadow_xer[`OPF_XER_CA];
    else
      cin = 1'b0;
  endfunction

  task automatic check_ops(input opf_pkg::inst_t i);
    opf_pkg::word_t a;
    opf_pkg::word_t b;
    opf_pkg::word_t c;
    logic           cin;
    model(i, a, b, c, cin);
    check_word("op_a", a, op_a);
    check_word("op_b", b, op_b);
    check_word("op_c", c, op_c);
    check_bit("op_cin", cin, op_cin);
    check_bit("op_so", shadow_xer[`OPF_XER_SO], op_so);
  endtask

  // ------------------------------------------------------------
  // issue and collect
  // ------------------------------------------------------------
  task automatic wait_ops(output int cycles);
    cycles = 0;
    while (!ops_valid) begin
      if (cycles == timeout)
        fail_run("ops_valid never came within the timeout");
      @(negedge clk);
      cycles++;
    end
  endtask

  // back-to-back issue, first bundle two falling edges after the drive, rest without gaps
  task automatic run_prog();
    int waited;
    fork
      begin
        foreach (prog[k]) begin
          inst_valid = 1'b1;
          inst = prog[k];
          @(negedge clk);
        end
        inst_valid = 1'b0;
      end
      begin
        foreach (prog[k]) begin
          wait_ops(waited);
          assert (waited == (k == 0 ? 2 : 0)) else
            fail_run($sformatf("ops_valid came after %0d cycles for instruction %0d",
                               waited, k));
          check_ops(prog[k]);
          @(negedge clk);
        end
      end
    join
    prog.delete();
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_reset_state();
    check_bit("ops_valid", 1'b0, ops_valid);
    check_word("op_a", '0, op_a);
    check_word("op_b", '0, op_b);
    check_word("op_c", '0, op_c);
    check_bit("op_cin", 1'b0, op_cin);
    check_bit("op_so", 1'b0, op_so);
  endtask

  task automatic test_ra_zero();
    // r0 nonzero so a plain add shows it
    load_gpr(5'd0, $random(seed) | 32'h1);
    load_gpr(5'd3, $random(seed));
    prog.push_back(d_form(`OPF_OP_ADDI, 5'd1, 5'd0, 16'h1234));
    prog.push_back(d_form(`OPF_OP_LWZ, 5'd2, 5'd0, 16'h0040));
    prog.push_back(x_form(5'd4, 5'd0, 5'd3, `OPF_XO_LWZX));
    prog.push_back(x_form(5'd5, 5'd0, 5'd3, xo_add));
    run_prog();
  endtask

  task automatic test_immediates();
    load_gpr(5'd5, $random(seed));
    prog.push_back(d_form(`OPF_OP_ADDI, 5'd1, 5'd5, 16'h8001));
    prog.push_back(d_form(`OPF_OP_ADDIS, 5'd1, 5'd5, 16'h8001));
    prog.push_back(d_form(`OPF_OP_ORI, 5'd1, 5'd5, 16'hf0f0));
    prog.push_back(d_form(`OPF_OP_ANDI, 5'd1, 5'd5, 16'h8000));
    prog.push_back(d_form(`OPF_OP_ORIS, 5'd1, 5'd5, 16'h00ff));
    run_prog();
  endtask

  task automatic test_special_operands();
    load_spr(`OPF_SPR_XER, $random(seed));
    load_spr(`OPF_SPR_CTR, $random(seed));
    load_spr(`OPF_SPR_LNK, $random(seed));
    load_spr(10'd22, $random(seed));
    load_gpr(5'd6, $random(seed) | 32'h8000_0000);
    load_gpr(5'd7, $random(seed) & 32'h7fff_ffff);
    prog.push_back(x_form(5'd1, 5'd6, 5'd7, `OPF_XO_NEG));
    prog.push_back(x_form(5'd1, 5'd6, 5'd7, `OPF_XO_ADDZE));
    prog.push_back(x_form(5'd1, 5'd6, 5'd7, `OPF_XO_ADDME));
    prog.push_back(mfspr_form(5'd1, `OPF_SPR_XER));
    prog.push_back(mfspr_form(5'd1, `OPF_SPR_CTR));
    prog.push_back(mfspr_form(5'd1, `OPF_SPR_LNK));
    prog.push_back(mfspr_form(5'd1, 10'd22));
    prog.push_back(x_form(5'd7, 5'd6, 5'd7, `OPF_XO_SRAW));
    prog.push_back(x_form(5'd6, 5'd7, 5'd3, `OPF_XO_SRAWI));
    run_prog();
  endtask

  task automatic test_carry_and_so();
    // CA and SO both set, then CA alone cleared
    load_spr(`OPF_SPR_XER, 32'ha000_0000);
    prog.push_back(x_form(5'd1, 5'd2, 5'd3, `OPF_XO_SUBF | 10'h200));
    prog.push_back(d_form(`OPF_OP_CMPI, 5'd0, 5'd2, 16'hfff0));
    prog.push_back(x_form(5'd1, 5'd2, 5'd3, xo_add));
    prog.push_back(x_form(5'd1, 5'd2, 5'd3, `OPF_XO_ADDE));
    prog.push_back(x_form(5'd1, 5'd2, 5'd0, `OPF_XO_ADDME));
    prog.push_back(x_form(5'd1, 5'd2, 5'd0, `OPF_XO_ADDZE | 10'h200));
    run_prog();
    load_spr(`OPF_SPR_XER, 32'h8000_0000);
    prog.push_back(x_form(5'd1, 5'd2, 5'd3, `OPF_XO_ADDE));
    prog.push_back(x_form(5'd1, 5'd2, 5'd0, `OPF_XO_ADDME));
    prog.push_back(x_form(5'd1, 5'd2, 5'd0, `OPF_XO_ADDZE));
    run_prog();
  endtask

  task automatic push_random_inst();
    opf_pkg::word_t r;
    logic [3:0]     kd;
    logic [3:0]     kx;
    r = $random(seed);
    kd = 4'($unsigned($random(seed)) % 13);
    kx = 4'($unsigned($random(seed)) % 12);
    if (r[31])
      prog.push_back(d_form(d_ops[kd], r[25:21], r[20:16], r[15:0]));
    else
      prog.push_back({`OPF_OP_ALU_XO, r[25:11], x_ops[kx], r[0]});
  endtask

  task automatic test_random_burst();
    for (int k = 0; k < 32; k++)
      load_gpr(5'(k), $random(seed));
    load_spr(`OPF_SPR_XER, $random(seed));
    load_spr(`OPF_SPR_CTR, $random(seed));
    load_spr(`OPF_SPR_LNK, $random(seed));
    repeat (16) push_random_inst();
    run_prog();
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    seed = 32'h54fc;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_ra_zero();
    test_immediates();
    test_special_operands();
    test_carry_and_so();
    test_random_burst();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+source
source/opf_pkg.sv
source/regfile_if.sv
source/register_file.sv
source/immediate_extract.sv
source/operand_fetch.sv
source/operand_fetch_top.sv
tests/operand_fetch_asserts.sv
tests/tb_operand_fetch.sv

/* Makefile */
TOP = tb_operand_fetch
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f \
	  --top-module $(TOP) -o $(TOP)

# the log decides the result, the simulator exit code is not trusted
run: build
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f sources.f \
	  --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
